//--- cpuTypesPkg.sv
`default_nettype none

package cpuTypesPkg;

    typedef logic [31:0] word;
    typedef logic [63:0] wideWord;
    typedef logic [3:0]  regIndex;

    typedef enum logic [4:0] {
        opLd   = 5'd0,
        opSt   = 5'd1,
        opAdd  = 5'd2,
        opSub  = 5'd3,
        opAnd  = 5'd4,
        opOr   = 5'd5,
        opNot  = 5'd6,
        opNeg  = 5'd7,
        opMul  = 5'd8,
        opMfhi = 5'd9,
        opMflo = 5'd10,
        opHalt = 5'd11
    } opcodeT;

    typedef enum logic [3:0] {
        aluPassB,
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNot,
        aluNeg,
        aluInc,
        aluMul
    } aluOpT;

    // ----------------------------------------
    // Instruction fields.
    // ----------------------------------------
    localparam int OpcodeLsb      = 27;
    localparam int RaLsb          = 23;
    localparam int RbLsb          = 19;
    localparam int RcLsb          = 15;
    localparam int AddrFieldWidth = 19;

    function automatic opcodeT opcodeOf(word instr);
        return opcodeT'(instr[31:OpcodeLsb]);
    endfunction

    function automatic regIndex raOf(word instr);
        return instr[RaLsb +: 4];
    endfunction

    function automatic regIndex rbOf(word instr);
        return instr[RbLsb +: 4];
    endfunction

    function automatic regIndex rcOf(word instr);
        return instr[RcLsb +: 4];
    endfunction

    // Memory word address of ld and st, zero extended.
    function automatic word addrOf(word instr);
        return {{(32 - AddrFieldWidth){1'b0}}, instr[AddrFieldWidth-1:0]};
    endfunction

endpackage

`default_nettype wire

//--- controlPkg.sv
`default_nettype none

package controlPkg;

    // Microsteps of one instruction.
    typedef enum logic [2:0] {
        T0,
        T1,
        T2,
        T3,
        T4,
        T5
    } stepT;

    typedef enum logic [1:0] {
        Run,
        BusRead,
        BusWrite,
        Halted
    } seqStateT;

    // Sources that can drive the internal bus.
    typedef enum logic [2:0] {
        srcGpr,
        srcPc,
        srcMdr,
        srcZlo,
        srcZhi,
        srcHi,
        srcLo,
        srcIr
    } busSrcT;

    // ----------------------------------------
    // Control word, one per clock.
    // ----------------------------------------
    typedef struct packed {
        busSrcT               busSrc;
        cpuTypesPkg::regIndex gprSel;
        logic                 pcIn;
        logic                 marIn;
        logic                 mdrIn;
        logic                 irIn;
        logic                 yIn;
        logic                 zIn;
        logic                 hiIn;
        logic                 loIn;
        logic                 gprIn;
        logic                 mdrFromMem;
        cpuTypesPkg::aluOpT   aluOp;
    } controlWord;

endpackage

`default_nettype wire

//--- aluUnit.sv
`default_nettype none

module aluUnit (
    input  wire cpuTypesPkg::aluOpT op,
    input  wire cpuTypesPkg::word   a,
    input  wire cpuTypesPkg::word   b,
    output cpuTypesPkg::wideWord    result
);
    import cpuTypesPkg::*;

    logic signed [63:0] aExt;
    logic signed [63:0] bExt;
    logic signed [63:0] product;

    // Sign extend first so the product is a true signed 64-bit value.
    assign aExt    = {{32{a[31]}}, a};
    assign bExt    = {{32{b[31]}}, b};
    assign product = aExt * bExt;

    always_comb begin
        result = '0;
        unique case (op)
            aluPassB: result[31:0] = b;
            aluAdd:   result[31:0] = a + b;
            aluSub:   result[31:0] = a - b;
            aluAnd:   result[31:0] = a & b;
            aluOr:    result[31:0] = a | b;
            aluNot:   result[31:0] = ~b;
            aluNeg:   result[31:0] = 32'd0 - b;
            aluInc:   result[31:0] = b + 32'd1;
            aluMul:   result       = product;
            default:  result       = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- stepTimer.sv
`default_nettype none

module stepTimer (
    input  wire Clock,
    input  wire rstN,
    input  wire advance,
    input  wire clear,
    output controlPkg::stepT step
);
    import controlPkg::*;

    // Clear wins over advance.
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            step <= T0;
        end else if (clear) begin
            step <= T0;
        end else if (advance) begin
            step <= stepT'(step + 3'd1);
        end
    end

endmodule

`default_nettype wire

//--- busRegisterFile.sv
`default_nettype none

module busRegisterFile (
    input  wire Clock,
    input  wire rstN,
    input  wire controlPkg::controlWord ctrl,
    input  wire cpuTypesPkg::word       memData,
    input  wire cpuTypesPkg::wideWord   aluResult,
    output cpuTypesPkg::word            irValue,
    output cpuTypesPkg::word            marValue,
    output cpuTypesPkg::word            mdrValue,
    output cpuTypesPkg::word            busValue,
    output cpuTypesPkg::word            yValue
);
    import cpuTypesPkg::*;
    import controlPkg::*;

    word     gpr [16];
    word     pc;
    word     ir;
    word     mar;
    word     mdr;
    word     y;
    wideWord z;
    word     hi;
    word     lo;

    // ----------------------------------------
    // Bus multiplexer.
    // ----------------------------------------
    always_comb begin
        unique case (ctrl.busSrc)
            srcGpr:  busValue = gpr[ctrl.gprSel];
            srcPc:   busValue = pc;
            srcMdr:  busValue = mdr;
            srcZlo:  busValue = z[31:0];
            srcZhi:  busValue = z[63:32];
            srcHi:   busValue = hi;
            srcLo:   busValue = lo;
            srcIr:   busValue = addrOf(ir);
            default: busValue = '0;
        endcase
    end

    // ----------------------------------------
    // Registers.
    // ----------------------------------------
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                gpr[i] <= '0;
            end
            pc  <= '0;
            ir  <= '0;
            mar <= '0;
            mdr <= '0;
            y   <= '0;
            z   <= '0;
            hi  <= '0;
            lo  <= '0;
        end else begin
            if (ctrl.gprIn) begin
                gpr[ctrl.gprSel] <= busValue;
            end
            if (ctrl.pcIn) begin
                pc <= busValue;
            end
            if (ctrl.irIn) begin
                ir <= busValue;
            end
            if (ctrl.marIn) begin
                mar <= busValue;
            end
            if (ctrl.mdrIn) begin
                mdr <= ctrl.mdrFromMem ? memData : busValue;
            end
            if (ctrl.yIn) begin
                y <= busValue;
            end
            if (ctrl.zIn) begin
                z <= aluResult;
            end
            // HI and LO load straight from the two halves of Z.
            if (ctrl.hiIn) begin
                hi <= z[63:32];
            end
            if (ctrl.loIn) begin
                lo <= z[31:0];
            end
        end
    end

    assign irValue  = ir;
    assign marValue = mar;
    assign mdrValue = mdr;
    assign yValue   = y;

endmodule

`default_nettype wire

//--- controlSequencer.sv
`default_nettype none

module controlSequencer (
    input  wire Clock,
    input  wire rstN,
    input  wire cpuTypesPkg::word ir,
    input  wire controlPkg::stepT step,
    output controlPkg::controlWord ctrl,
    output logic stepAdvance,
    output logic stepClear,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    input  wire wbAck,
    output logic halted
);
    import cpuTypesPkg::*;
    import controlPkg::*;

    seqStateT state;
    seqStateT nextState;
    opcodeT   opcode;
    regIndex  ra;
    regIndex  rb;
    regIndex  rc;
    aluOpT    execOp;

    assign opcode = opcodeOf(ir);
    assign ra     = raOf(ir);
    assign rb     = rbOf(ir);
    assign rc     = rcOf(ir);

    always_comb begin
        unique case (opcode)
            opAdd:   execOp = aluAdd;
            opSub:   execOp = aluSub;
            opAnd:   execOp = aluAnd;
            opOr:    execOp = aluOr;
            opNot:   execOp = aluNot;
            opNeg:   execOp = aluNeg;
            opMul:   execOp = aluMul;
            default: execOp = aluPassB;
        endcase
    end

    // ----------------------------------------
    // Step and state decode.
    // ----------------------------------------
    always_comb begin
        ctrl        = '0;
        stepAdvance = 1'b0;
        stepClear   = 1'b0;
        nextState   = state;
        unique case (state)
            Run: begin
                if (step == T0) begin
                    // PC to MAR, PC plus one into Z, then fetch.
                    ctrl.busSrc = srcPc;
                    ctrl.marIn  = 1'b1;
                    ctrl.aluOp  = aluInc;
                    ctrl.zIn    = 1'b1;
                    stepAdvance = 1'b1;
                    nextState   = BusRead;
                end else if (step == T2) begin
                    // MAR also takes the word, so st has its address in T4.
                    ctrl.busSrc = srcMdr;
                    ctrl.irIn   = 1'b1;
                    ctrl.marIn  = 1'b1;
                    stepAdvance = 1'b1;
                end else begin
                    unique case (opcode)
                        opLd: begin
                            if (step == T3) begin
                                ctrl.busSrc = srcIr;
                                ctrl.marIn  = 1'b1;
                                stepAdvance = 1'b1;
                                nextState   = BusRead;
                            end else begin
                                ctrl.busSrc = srcMdr;
                                ctrl.gprSel = ra;
                                ctrl.gprIn  = 1'b1;
                                stepClear   = 1'b1;
                            end
                        end
                        opSt: begin
                            ctrl.gprSel = ra;
                            ctrl.mdrIn  = 1'b1;
                            stepAdvance = 1'b1;
                            nextState   = BusWrite;
                        end
                        opAdd, opSub, opAnd, opOr, opMul: begin
                            if (step == T3) begin
                                ctrl.gprSel = rb;
                                ctrl.yIn    = 1'b1;
                                stepAdvance = 1'b1;
                            end else if (step == T4) begin
                                ctrl.gprSel = rc;
                                ctrl.aluOp  = execOp;
                                ctrl.zIn    = 1'b1;
                                stepAdvance = 1'b1;
                            end else if (opcode == opMul) begin
                                ctrl.hiIn = 1'b1;
                                ctrl.loIn = 1'b1;
                                stepClear = 1'b1;
                            end else begin
                                ctrl.busSrc = srcZlo;
                                ctrl.gprSel = ra;
                                ctrl.gprIn  = 1'b1;
                                stepClear   = 1'b1;
                            end
                        end
                        opNot, opNeg: begin
                            if (step == T3) begin
                                ctrl.gprSel = rb;
                                ctrl.aluOp  = execOp;
                                ctrl.zIn    = 1'b1;
                                stepAdvance = 1'b1;
                            end else begin
                                ctrl.busSrc = srcZlo;
                                ctrl.gprSel = ra;
                                ctrl.gprIn  = 1'b1;
                                stepClear   = 1'b1;
                            end
                        end
                        opMfhi, opMflo: begin
                            ctrl.busSrc = (opcode == opMfhi) ? srcHi : srcLo;
                            ctrl.gprSel = ra;
                            ctrl.gprIn  = 1'b1;
                            stepClear   = 1'b1;
                        end
                        opHalt: begin
                            stepClear = 1'b1;
                            nextState = Halted;
                        end
                        default: stepClear = 1'b1;
                    endcase
                end
            end
            BusRead: begin
                if (wbAck) begin
                    ctrl.mdrIn      = 1'b1;
                    ctrl.mdrFromMem = 1'b1;
                    if (step == T1) begin
                        ctrl.busSrc = srcZlo;
                        ctrl.pcIn   = 1'b1;
                    end
                    stepAdvance = 1'b1;
                    nextState   = Run;
                end
            end
            BusWrite: begin
                if (wbAck) begin
                    stepClear = 1'b1;
                    nextState = Run;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            state <= Run;
        end else begin
            state <= nextState;
        end
    end

    assign wbCyc  = (state == BusRead) || (state == BusWrite);
    assign wbStb  = wbCyc;
    assign wbWe   = (state == BusWrite);
    assign halted = (state == Halted);

endmodule

`default_nettype wire

//--- datapathTop.sv
`default_nettype none

module datapathTop #(
    parameter int AddrWidth = 16
) (
    input  wire Clock,
    input  wire rstN,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output logic [AddrWidth-1:0] wbAdr,
    output cpuTypesPkg::word wbDatW,
    input  wire cpuTypesPkg::word wbDatR,
    input  wire wbAck,
    output logic halted
);
    import cpuTypesPkg::*;
    import controlPkg::*;

    controlWord ctrl;
    stepT       step;
    logic       stepAdvance;
    logic       stepClear;
    word        irValue;
    word        marValue;
    word        mdrValue;
    word        busValue;
    word        yValue;
    wideWord    aluResult;

    controlSequencer sequencer (
        .Clock       (Clock),
        .rstN        (rstN),
        .ir          (irValue),
        .step        (step),
        .ctrl        (ctrl),
        .stepAdvance (stepAdvance),
        .stepClear   (stepClear),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbWe        (wbWe),
        .wbAck       (wbAck),
        .halted      (halted)
    );

    stepTimer timer (
        .Clock   (Clock),
        .rstN    (rstN),
        .advance (stepAdvance),
        .clear   (stepClear),
        .step    (step)
    );

    busRegisterFile regFile (
        .Clock     (Clock),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .memData   (wbDatR),
        .aluResult (aluResult),
        .irValue   (irValue),
        .marValue  (marValue),
        .mdrValue  (mdrValue),
        .busValue  (busValue),
        .yValue    (yValue)
    );

    aluUnit alu (
        .op     (ctrl.aluOp),
        .a      (yValue),
        .b      (busValue),
        .result (aluResult)
    );

    // Word address from MAR, write data from MDR.
    assign wbAdr  = marValue[AddrWidth-1:0];
    assign wbDatW = mdrValue;

endmodule

`default_nettype wire

//--- datapath_props.sv
`default_nettype none

module datapathProps #(
    parameter int AddrWidth = 16
) (
    input wire                   Clock,
    input wire                   rstN,
    input wire                   wbCyc,
    input wire                   wbStb,
    input wire                   wbWe,
    input wire [AddrWidth-1:0]   wbAdr,
    input wire cpuTypesPkg::word wbDatW,
    input wire                   wbAck,
    input wire                   halted
);
    timeunit 1ns;
    timeprecision 100ps;

    // Bus and halt flag are quiet while reset is held.
    resetQuiet: assert property (@(posedge Clock) !rstN |-> !wbCyc && !wbStb && !halted)
        else $error("bus cycle or halted active during reset");

    // ----------------------------------------
    // Master holds the request until ack.
    // ----------------------------------------
    holdWhileWaiting: assert property (@(posedge Clock) disable iff (!rstN)
        wbStb && !wbAck |=> wbStb && $stable(wbWe) && $stable(wbAdr) && $stable(wbDatW))
        else $error("request changed while waiting for ack");

    endAfterAck: assert property (@(posedge Clock) disable iff (!rstN)
        wbCyc && wbAck |=> !wbCyc)
        else $error("wbCyc still high after ack");

    quietAfterHalt: assert property (@(posedge Clock) disable iff (!rstN)
        halted |=> halted && !wbCyc && !wbStb)
        else $error("bus cycle or halted drop after halt");

endmodule

`default_nettype wire

//--- datapathTb.sv
`default_nettype none

module datapathTb;
    timeunit 1ns;
    timeprecision 100ps;

    import cpuTypesPkg::*;

    localparam int AddrWidth      = 8;
    localparam int MemWords       = 1 << AddrWidth;
    localparam int ImageWords     = 2 * MemWords;
    localparam int ExpectBase     = MemWords;
    localparam int ProgramLength  = 20;
    localparam int ClockPeriod    = 4;
    localparam int ResetCycles    = 16;
    localparam int PostHaltCycles = 32;
    localparam int WatchdogCycles = 40 * ProgramLength * 4 + ResetCycles;
    localparam logic [31:0] Seed  = 32'h0a0b_0742;

    logic                 Clock;
    logic                 rstN;
    logic                 wbCyc;
    logic                 wbStb;
    logic                 wbWe;
    logic [AddrWidth-1:0] wbAdr;
    word                  wbDatW;
    word                  wbDatR;
    logic                 wbAck;
    logic                 halted;

    // Lower half is the memory, upper half holds the expected stores.
    word image [ImageWords];
    int  expectCount;
    int  storeCount;

    datapathTop #(.AddrWidth(AddrWidth)) dut (
        .Clock  (Clock),
        .rstN   (rstN),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck),
        .halted (halted)
    );

    bind datapathTop datapathProps #(.AddrWidth(AddrWidth)) props (
        .Clock  (Clock),
        .rstN   (rstN),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbAck  (wbAck),
        .halted (halted)
    );

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string signalName, input word actual, input word expected);
        if (actual !== expected) begin
            stopWithFailure($sformatf("error at %0d ns: %s is 0x%h, expected 0x%h",
                                      $time, signalName, actual, expected));
        end
    endtask

    // Each write must match the next entry of the expected list.
    task automatic recordStore();
        if (storeCount >= expectCount) begin
            stopWithFailure("a store was seen beyond the end of the expected list");
        end else begin
            checkValue("wbAdr", word'(wbAdr), image[ExpectBase + 1 + 2 * storeCount]);
            checkValue("wbDatW", wbDatW, image[ExpectBase + 2 + 2 * storeCount]);
            image[int'(wbAdr)] = wbDatW;
            storeCount++;
        end
    endtask

    initial begin : clockGen
        Clock = 1'b0;
        forever begin
            #(ClockPeriod / 2) Clock = ~Clock;
        end
    end

    // ----------------------------------------
    // Wishbone memory model.
    // ----------------------------------------
    initial begin : busSlave
        int   waitLeft;
        logic busy;
        void'($urandom(Seed));
        wbAck      = 1'b0;
        wbDatR     = '0;
        busy       = 1'b0;
        waitLeft   = 0;
        storeCount = 0;
        for (int i = 0; i < ImageWords; i++) begin
            image[i] = 32'hc0de_0000 ^ word'(i);
        end
        $readmemh("programInput.mem", image);
        expectCount = int'(image[ExpectBase]);
        forever begin
            @(posedge Clock);
            #1;
            if (wbAck) begin
                wbAck = 1'b0;
                busy  = 1'b0;
            end else if (wbCyc && wbStb) begin
                if (!busy) begin
                    busy     = 1'b1;
                    waitLeft = int'($urandom_range(3, 0));
                end
                if (waitLeft > 0) begin
                    waitLeft--;
                end else begin
                    if (wbWe) begin
                        recordStore();
                    end else begin
                        wbDatR = image[int'(wbAdr)];
                    end
                    wbAck = 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // Reset, run to halt, idle bus after halt.
    // ----------------------------------------
    initial begin : mainSequence
        // Start high so that the drop is a real falling edge.
        rstN = 1'b1;
        #1 rstN = 1'b0;
        repeat (ResetCycles) begin
            @(posedge Clock);
            #1;
            checkValue("wbCyc", word'(wbCyc), 32'd0);
            checkValue("wbStb", word'(wbStb), 32'd0);
            checkValue("halted", word'(halted), 32'd0);
        end
        rstN = 1'b1;
        // Idle in T0 for one clock, then the first fetch reads address zero.
        @(negedge Clock);
        checkValue("wbCyc", word'(wbCyc), 32'd0);
        checkValue("wbStb", word'(wbStb), 32'd0);
        checkValue("halted", word'(halted), 32'd0);
        @(negedge Clock);
        checkValue("wbCyc", word'(wbCyc), 32'd1);
        checkValue("wbWe", word'(wbWe), 32'd0);
        checkValue("wbAdr", word'(wbAdr), 32'd0);
        while (!halted) begin
            @(negedge Clock);
        end
        repeat (PostHaltCycles) begin
            @(negedge Clock);
            checkValue("halted", word'(halted), 32'd1);
            checkValue("wbCyc", word'(wbCyc), 32'd0);
            checkValue("wbStb", word'(wbStb), 32'd0);
        end
        checkValue("store count", word'(storeCount), word'(expectCount));
        $display("TEST PASS");
        $finish;
    end

    initial begin : watchdog
        repeat (WatchdogCycles) begin
            @(posedge Clock);
        end
        stopWithFailure($sformatf("timeout: the program did not halt within %0d cycles",
                                  WatchdogCycles));
    end

endmodule

`default_nettype wire

//--- programInput.mem
// Hex words placed at @ word addresses. Program from 000, operands at 040.
// From 100 on: expected store count, then one store per line as address and data.
@000
00800040 // ld   r1, [40]
01000041 // ld   r2, [41]
11890000 // add  r3, r1, r2
09800080 // st   r3, [80]
1a090000 // sub  r4, r1, r2
0a000081 // st   r4, [81]
22890000 // and  r5, r1, r2
0a800082 // st   r5, [82]
2b090000 // or   r6, r1, r2
0b000083 // st   r6, [83]
33880000 // not  r7, r1
0b800084 // st   r7, [84]
3c080000 // neg  r8, r1
0c000085 // st   r8, [85]
40090000 // mul  r1, r2
4c800000 // mfhi r9
55000000 // mflo r10
0c800086 // st   r9, [86]
0d000087 // st   r10, [87]
58000000 // halt
@040
00030005
ffff0000
@100
00000008
00000080 00020005
00000081 00040005
00000082 00030000
00000083 ffff0005
00000084 fffcfffa
00000085 fffcfffb
00000086 fffffffc
00000087 fffb0000

//--- compile.f
cpuTypesPkg.sv
controlPkg.sv
aluUnit.sv
stepTimer.sv
busRegisterFile.sv
controlSequencer.sv
datapathTop.sv
datapath_props.sv
datapathTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the datapath testbench with Verilator.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f compile.f --top-module datapathTb -o datapathSim
./obj_dir/datapathSim | tee sim.log
if grep -q "^TEST PASS$" sim.log; then
    echo "Simulation passed."
    exit 0
else
    echo "Simulation failed, see sim.log."
    exit 1
fi
